// File: src/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    localparam int DATA_W    = 114;
    localparam int PARITY_W  = 8;
    localparam int HAMMING_W = 7; // the overall parity bit sits above these.

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [PARITY_W-1:0] parity_t;
    typedef logic [PARITY_W-1:0] syndrome_t;

    typedef struct packed {
        data_t   data;
        parity_t parity;
    } codeword_t;

    typedef struct packed {
        codeword_t word;
        syndrome_t syndrome;
        parity_t   regen;   // parity recomputed from the received data.
        logic      bypass;
    } check_t;

    typedef struct packed {
        data_t   data_out;
        parity_t parity_out;
        logic    sbit_err;
        logic    dbit_err;
    } result_t;

    // Data bits occupy the Hamming positions from 3 upward and skip every power of two,
    // so index 0 lands on position 3 and index 113 on position 121.
    function automatic logic [HAMMING_W-1:0] data_position(input int unsigned idx);
        int unsigned          seen;
        logic [HAMMING_W-1:0] pos;
        seen = 0;
        pos  = '0;
        for (int unsigned p = 3; p < (1 << HAMMING_W); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (seen == idx) begin
                    pos = HAMMING_W'(p);
                end
                seen++;
            end
        end
        return pos;
    endfunction

    // only even-weight positions feed the overall check bit.
    function automatic logic even_weight(input logic [HAMMING_W-1:0] pos);
        return ~^pos;
    endfunction

endpackage

`default_nettype wire

// File: src/ecc_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_encoder
    import ecc_pkg::*;
(
    input  data_t   data,
    output parity_t parity
);

    // taps[i] lists the check bits that data bit i contributes to.
    parity_t taps [DATA_W];

    for (genvar i = 0; i < DATA_W; i++) begin : g_taps
        assign taps[i] = {even_weight(data_position(i)), data_position(i)};
    end

    // The taps are constant, so each check bit reduces to a plain XOR tree over
    // the data bits that have its tap set.
    always_comb begin
        parity = '0;
        for (int i = 0; i < DATA_W; i++) begin
            parity ^= taps[i] & {PARITY_W{data[i]}};
        end
    end

endmodule

`default_nettype wire

// File: src/ecc_check_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_check_stage
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  codeword_t in_word,
    input  logic      bypass,
    output logic      chk_valid,
    output check_t    chk
);

    parity_t   regen;
    syndrome_t syndrome;

    ecc_encoder i_ecc_encoder (
        .data   (in_word.data),
        .parity (regen)
    );

    assign syndrome = in_word.parity ^ regen; // zero for a clean codeword.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= in_valid;
        end
    end

    // The payload only moves when a word is accepted.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            chk.word     <= in_word;
            chk.syndrome <= syndrome;
            chk.regen    <= regen;
            chk.bypass   <= bypass; // bypass travels with its own word.
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(chk_valid))
        else $error("chk_valid is unknown after reset");

endmodule

`default_nettype wire

// File: src/ecc_syndrome_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_syndrome_decoder
    import ecc_pkg::*;
(
    input  syndrome_t syndrome,
    output data_t     mask,
    output logic      single_err,
    output logic      double_err
);

    logic data_hit;
    logic check_hit;

    // A flipped data bit leaves its position in the low syndrome bits together with
    // the overall parity that position carries. Positions outside 3 to 121 never match.
    for (genvar i = 0; i < DATA_W; i++) begin : g_match
        assign mask[i] = (syndrome[HAMMING_W-1:0] == data_position(i)) &&
                         (syndrome[PARITY_W-1] == even_weight(data_position(i)));
    end

    assign data_hit  = |mask;
    assign check_hit = $onehot(syndrome); // a single check bit flipped and the data is intact.

    assign single_err = data_hit || check_hit;
    assign double_err = (syndrome != '0) && !single_err;

    // Two data flips always leave the overall bit opposite to the parity of the
    // combined position, so they can never alias to a single correction.
    always_comb begin
        if (!$isunknown(syndrome)) begin
            assert (!(single_err && double_err) && $onehot0(mask) &&
                    (!single_err || ^syndrome))
                else $error("syndrome decoded to an inconsistent error class");
        end
    end

endmodule

`default_nettype wire

// File: src/ecc_correct_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    chk_valid,
    input  check_t  chk,
    output logic    out_valid,
    output result_t out_result
);

    data_t   mask;
    logic    single_err;
    logic    double_err;
    result_t result;

    ecc_syndrome_decoder i_ecc_syndrome_decoder (
        .syndrome   (chk.syndrome),
        .mask       (mask),
        .single_err (single_err),
        .double_err (double_err)
    );

    always_comb begin
        result.parity_out = chk.regen; // reported whether or not bypass is set.
        if (chk.bypass) begin
            result.data_out = chk.word.data;
            result.sbit_err = 1'b0;
            result.dbit_err = 1'b0;
        end else begin
            // the mask is zero unless a data bit needs flipping back.
            result.data_out = chk.word.data ^ mask;
            result.sbit_err = single_err;
            result.dbit_err = double_err;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= chk_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (chk_valid) begin
            out_result <= result;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(out_result.sbit_err && out_result.dbit_err))
        else $error("single and double error flagged on the same word");

endmodule

`default_nettype wire

// File: src/ecc_114_top.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_114_top
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  codeword_t in_word,
    input  logic      bypass,
    output logic      out_valid,
    output result_t   out_result
);

    logic   chk_valid;
    check_t chk;

    // Stage 1 checks the word and stage 2 corrects it. Neither stage can stall.
    ecc_check_stage i_ecc_check_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .bypass    (bypass),
        .chk_valid (chk_valid),
        .chk       (chk)
    );

    ecc_correct_stage i_ecc_correct_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .chk_valid  (chk_valid),
        .chk        (chk),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    // every accepted word leaves through stage 2 exactly two edges later.
    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> ##2 out_valid)
        else $error("out_valid missing two cycles after an accepted word");

    assert property (@(posedge clk) disable iff (!rst_n) !in_valid |-> ##2 !out_valid)
        else $error("out_valid raised without an accepted word");

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    // reset is released just after an edge, like every other input.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/ecc_114_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_114_tb
    import ecc_pkg::*;
();

    localparam int CW_W = DATA_W + PARITY_W;
    // 1162 words plus about one idle cycle in eight and the reset need some 1350 cycles.
    localparam int unsigned TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        result_t     result;
        int unsigned cycle;   // edge at which the word was accepted.
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    codeword_t   in_word;
    logic        bypass;
    logic        out_valid;
    result_t     out_result;

    result_t              exp_next;
    expect_t              sb_queue [$];
    expect_t              head;
    logic                 head_valid = 1'b0;
    int unsigned          cycle = 0;
    logic [63:0]          rng_state = 64'd45;
    logic [HAMMING_W-1:0] position_of [DATA_W];

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ecc_114_top i_ecc_114_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    function automatic logic [63:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    function automatic int rand_below(input int unsigned n);
        return int'(next_rand() % 64'(n));
    endfunction

    function automatic data_t random_data();
        logic [127:0] wide;
        wide = {next_rand(), next_rand()};
        return wide[DATA_W-1:0];
    endfunction

    // data bits take the positions from 3 to 121 that are not powers of two.
    task automatic build_positions();
        int idx;
        idx = 0;
        for (int p = 3; p <= 121; p++) begin
            if ($countones(p) != 1) begin
                position_of[idx] = HAMMING_W'(p);
                idx++;
            end
        end
    endtask

    function automatic parity_t model_parity(input data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (d[i]) begin
                p[HAMMING_W-1:0] ^= position_of[i];
                if ($countones(position_of[i]) % 2 == 0) begin
                    p[PARITY_W-1] ^= 1'b1; // overall bit covers even-weight positions.
                end
            end
        end
        return p;
    endfunction

    // flip_a and flip_b index the 122 codeword bits, and -1 means no flip.
    task automatic send_word(input data_t data, input int flip_a, input int flip_b,
                             input logic byp);
        logic [CW_W-1:0] bits;
        codeword_t       clean;
        codeword_t       rx;
        result_t         exp;
        int              flips;
        clean.data   = data;
        clean.parity = model_parity(data);
        bits  = clean;
        flips = 0;
        if (flip_a >= 0) begin
            bits[flip_a] = ~bits[flip_a];
            flips++;
        end
        if (flip_b >= 0) begin
            bits[flip_b] = ~bits[flip_b];
            flips++;
        end
        rx = bits;
        exp.parity_out = model_parity(rx.data);
        exp.sbit_err   = !byp && (flips == 1);
        exp.dbit_err   = !byp && (flips == 2);
        exp.data_out   = (!byp && flips == 1) ? data : rx.data;
        while ((next_rand() & 64'd7) == 0) begin
            @(posedge clk);
            #1 in_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_word  = rx;
        bypass   = byp;
        exp_next = exp;
    endtask

    task automatic report_mismatch(input string what);
        $display("[FAIL] %0d ns: %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "scoreboard check failed");
    endtask

    always @(posedge clk) begin
        if (rst_n && in_valid) begin
            sb_queue.push_back({exp_next, cycle});
        end
        if (rst_n && out_valid && sb_queue.size() != 0) begin
            void'(sb_queue.pop_front());
        end
        head_valid <= (sb_queue.size() != 0);
        if (sb_queue.size() != 0) begin
            head <= sb_queue[0];
        end
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
        else report_mismatch("out_valid is unknown");

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> head_valid)
        else report_mismatch("out_valid high with no word pending");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_result == head.result)
        else report_mismatch($sformatf("expected %h, got %h",
                                       $sampled(head.result), $sampled(out_result)));

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> cycle == head.cycle + 2)
        else report_mismatch("word left at the wrong latency");

    assert property (@(posedge clk) disable iff (!rst_n)
        (head_valid && cycle == head.cycle + 2) |-> out_valid)
        else report_mismatch("word not delivered two cycles after it was accepted");

    initial begin
        int a;
        int b;
        int n;
        in_valid = 1'b0;
        in_word  = '0;
        bypass   = 1'b0;
        exp_next = '0;
        build_positions();
        @(posedge rst_n);
        repeat (100) send_word(random_data(), -1, -1, 1'b0);
        for (int i = 0; i < DATA_W; i++) begin
            send_word(random_data(), PARITY_W + i, -1, 1'b0);
        end
        repeat (200) send_word(random_data(), PARITY_W + rand_below(DATA_W), -1, 1'b0);
        for (int k = 0; k < PARITY_W; k++) begin
            send_word(random_data(), k, -1, 1'b0);
        end
        repeat (40) send_word(random_data(), rand_below(PARITY_W), -1, 1'b0);
        repeat (400) begin
            a = rand_below(CW_W);
            b = rand_below(CW_W - 1);
            if (b >= a) b++; // keeps the two flips distinct.
            send_word(random_data(), a, b, 1'b0);
        end
        repeat (300) begin
            n = rand_below(3);
            a = rand_below(CW_W);
            b = rand_below(CW_W - 1);
            if (b >= a) b++;
            send_word(random_data(), (n > 0) ? a : -1, (n > 1) ? b : -1, 1'b1);
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
        while (sb_queue.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        if (out_valid) begin
            $display("out_valid is still high after the last word drained");
            $display("SOME TESTS FAILED");
            $fatal(1, "stray output");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: all.f
src/ecc_pkg.sv
src/ecc_encoder.sv
src/ecc_check_stage.sv
src/ecc_syndrome_decoder.sv
src/ecc_correct_stage.sv
src/ecc_114_top.sv
tests/tb_clock_gen.sv
tests/ecc_114_tb.sv

// File: run.sh
#!/bin/sh
# Builds the ECC pipeline testbench with Verilator and runs it.
# A $fatal in the testbench gives a non-zero exit status, which ends this script.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module ecc_114_tb \
    -f all.f \
    -o ecc_114_sim

./obj_dir/ecc_114_sim
